//--- Bender.yml
package:
  name: smc

sources:
  - hw/smc_pkg.sv
  - hw/smc_apb_if.sv
  - hw/smc_wait_timer.sv
  - hw/smc_data_path.sv
  - hw/smc_state_machine.sv
  - hw/smc_top.sv
  - target: test
    files:
      - bench/smc_sram_model.sv
      - bench/smc_chk.sv
      - bench/smc_tb.sv

//--- bench/smc_chk.sv
/*
 * Protocol assertions for the memory pins and Wishbone ack
 * Bound to the controller top level
 */

`timescale 1ns/1ps
`default_nettype none

module smc_chk (
  input wire pclk,
  input wire reset,
  input wire wb_ack,
  input wire mem_doe,
  input wire mem_cs_n,
  input wire mem_oe_n,
  input wire mem_we_n
);

  int unsigned fails = 0;  // Assertion failures so far

  // Never read and write strobe together
  a_one_strobe: assert property (@(posedge pclk) disable iff (reset) mem_oe_n || mem_we_n)
    else
    begin
      $error("mem_oe_n and mem_we_n both low");
      fails++;
    end

  a_strobe_in_cs: assert property (@(posedge pclk) disable iff (reset)
                                   (!mem_oe_n || !mem_we_n) |-> !mem_cs_n)
    else
    begin
      $error("strobe low while mem_cs_n high");
      fails++;
    end

  a_ack_pulse: assert property (@(posedge pclk) disable iff (reset) wb_ack |=> !wb_ack)
    else
    begin
      $error("wb_ack high on two cycles in a row");
      fails++;
    end

  // Bus driven only under the write strobe
  a_doe_in_write: assert property (@(posedge pclk) disable iff (reset) mem_doe |-> !mem_we_n)
    else
    begin
      $error("mem_doe high outside the write strobe");
      fails++;
    end

endmodule

`default_nettype wire

//--- bench/smc_sram_model.sv
/*
 * Behavioral asynchronous SRAM, 32-bit words with byte lanes
 * Address-based fill pattern, level-sensitive write, gated read
 */

`timescale 1ns/1ps
`default_nettype none

module smc_sram_model (
  input  wire smc_pkg::addr_t  addr,
  input  wire smc_pkg::data_t  wdata,
  input  wire                  drive,  // Controller owns the data bus
  input  wire                  cs_n,
  input  wire                  oe_n,
  input  wire                  we_n,
  input  wire smc_pkg::sel_t   be_n,
  output smc_pkg::data_t       rdata
);

  smc_pkg::data_t mem [0:(1 << smc_pkg::ADDR_W)-1];

  // Fill with a word unique to each address
  initial
  begin
    for (int a = 0; a < (1 << smc_pkg::ADDR_W); a++)
    begin
      mem[a] = {~smc_pkg::addr_t'(a), smc_pkg::addr_t'(a)};
    end
  end

  // Write is transparent while the strobe is low
  always @*
  begin
    if (!cs_n && !we_n && drive)
    begin
      for (int lane = 0; lane < smc_pkg::SEL_W; lane++)
      begin
        if (!be_n[lane])
        begin
          mem[addr][8*lane +: 8] = wdata[8*lane +: 8];
        end
      end
    end
  end

  assign rdata = (!cs_n && !oe_n) ? mem[addr] : 'x;  // Floating bus shows as X

endmodule

`default_nettype wire

//--- bench/smc_tb.sv
/*
 * Testbench for the static memory controller
 * Clock and reset, APB and Wishbone host tasks, shadow memory
 * Reference functions for read data and ack latency, compare process
 */

`timescale 1ns/1ps
`default_nettype none

module smc_tb;

  localparam int ACK_TIMEOUT   = 64;  // Cycles allowed for wb_ack
  localparam int DRAIN_TIMEOUT = 16;

  logic                pclk;
  logic                reset;
  logic                psel;
  logic                penable;
  logic                pwrite;
  smc_pkg::apb_addr_t  paddr;
  smc_pkg::data_t      pwdata;
  smc_pkg::data_t      prdata;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  smc_pkg::addr_t      wb_adr;
  smc_pkg::sel_t       wb_sel;
  smc_pkg::data_t      wb_dat_w;
  smc_pkg::data_t      wb_dat_r;
  logic                wb_ack;
  smc_pkg::addr_t      mem_addr;
  smc_pkg::data_t      mem_dout;
  logic                mem_doe;
  logic                mem_cs_n;
  logic                mem_oe_n;
  logic                mem_we_n;
  smc_pkg::sel_t       mem_be_n;
  smc_pkg::data_t      mem_din;

  // Pending checks, drained by the compare process
  string               sig_q[$];
  smc_pkg::data_t      got_q[$];
  smc_pkg::data_t      exp_q[$];
  time                 time_q[$];
  int                  check_count = 0;
  int                  error_count = 0;
  int                  test_num = 0;
  int                  test_checks;  // Counts when the test began
  int                  test_errors;

  smc_pkg::data_t      shadow[smc_pkg::addr_t];  // Words written so far
  int                  cur_rd;                   // Timing as last written over APB
  int                  cur_wr;
  int                  cur_hold;

  smc_top UUT (
    .pclk (pclk), .reset (reset),
    .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_sel (wb_sel), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .mem_addr (mem_addr), .mem_dout (mem_dout), .mem_doe (mem_doe),
    .mem_cs_n (mem_cs_n), .mem_oe_n (mem_oe_n), .mem_we_n (mem_we_n),
    .mem_be_n (mem_be_n), .mem_din (mem_din)
  );

  smc_sram_model i_sram (
    .addr (mem_addr), .wdata (mem_dout), .drive (mem_doe), .cs_n (mem_cs_n),
    .oe_n (mem_oe_n), .we_n (mem_we_n), .be_n (mem_be_n), .rdata (mem_din)
  );

  bind smc_top smc_chk i_chk (
    .pclk (pclk), .reset (reset), .wb_ack (wb_ack), .mem_doe (mem_doe),
    .mem_cs_n (mem_cs_n), .mem_oe_n (mem_oe_n), .mem_we_n (mem_we_n)
  );

  initial
  begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;  // 40 ns period
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic smc_pkg::data_t pack_cfg(input int rd, input int wr, input int hold);
    return smc_pkg::data_t'((hold << 8) | (wr << 4) | rd);  // prdata layout
  endfunction

  function automatic smc_pkg::data_t known_word(input smc_pkg::addr_t a);
    if (shadow.exists(a))
    begin
      return shadow[a];
    end
    else
    begin
      return {~a, a};  // Untouched word keeps the SRAM fill
    end
  endfunction

  // Expected word after a write, by byte lane
  function automatic smc_pkg::data_t merge_bytes(input smc_pkg::data_t old,
                                                 input smc_pkg::data_t wdat,
                                                 input smc_pkg::sel_t sel);
    smc_pkg::data_t r;
    r = old;
    for (int i = 0; i < smc_pkg::SEL_W; i++)
    begin
      if (sel[i]) r[8*i +: 8] = wdat[8*i +: 8];
    end
    return r;
  endfunction

  function automatic int ack_latency(input logic we);
    return (we ? cur_wr : cur_rd) + cur_hold + 2;  // Setup, access W+1, hold, ack
  endfunction

  // --------------------------------------------------
  // Compare process
  // --------------------------------------------------
  task automatic push_check(input string sig, input smc_pkg::data_t got,
                            input smc_pkg::data_t exp);
    sig_q.push_back(sig);
    got_q.push_back(got);
    exp_q.push_back(exp);
    time_q.push_back($time);
  endtask

  always @(posedge pclk)
  begin
    while (got_q.size() != 0)
    begin
      check_count++;
      if (got_q[0] !== exp_q[0])
      begin
        error_count++;
        $display("error at time %0t: %s got %h expected %h",
                 time_q[0], sig_q[0], got_q[0], exp_q[0]);
      end
      void'(sig_q.pop_front());
      void'(got_q.pop_front());
      void'(exp_q.pop_front());
      void'(time_q.pop_front());
    end
  end

  task automatic stop_on_timeout(input string why);
    $display("timeout at time %0t: %s", $time, why);
    $display("%0d checks, %0d errors", check_count, error_count);
    $display("Errors found");
    $finish;
  endtask

  task automatic start_test();
    test_num++;
    test_checks = check_count;
    test_errors = error_count;
  endtask

  task automatic end_test(input string name);
    int waited;
    waited = 0;
    while (got_q.size() != 0 && waited < DRAIN_TIMEOUT)
    begin
      @(posedge pclk);
      waited++;
    end
    if (got_q.size() != 0)
    begin
      stop_on_timeout("compare queue never drained");
    end
    else
    begin
      $display("test %0d %s: %0d checks, %0d errors", test_num, name,
               check_count - test_checks, error_count - test_errors);
    end
  endtask

  // --------------------------------------------------
  // APB host, no wait states
  // --------------------------------------------------
  task automatic apb_write(input smc_pkg::apb_addr_t a, input smc_pkg::data_t d);
    @(posedge pclk);
    psel    <= 1'b1;  // Setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge pclk);
    penable <= 1'b1;  // Access phase
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input smc_pkg::apb_addr_t a, output smc_pkg::data_t d);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge pclk);
    penable <= 1'b1;
    @(negedge pclk);
    d = prdata;  // Valid in the access phase
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic set_config(input int rd, input int wr, input int hold);
    apb_write(smc_pkg::CFG_ADDR, pack_cfg(rd, wr, hold));
    cur_rd   = rd;
    cur_wr   = wr;
    cur_hold = hold;
  endtask

  // --------------------------------------------------
  // Wishbone host
  // --------------------------------------------------
  // Latency counts cycles from the accepting edge to the ack cycle
  task automatic wb_cycle(input logic we, input smc_pkg::addr_t adr, input smc_pkg::sel_t sel,
                          input smc_pkg::data_t wdat, output smc_pkg::data_t rdat,
                          output int lat);
    int cycles;
    @(posedge pclk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_sel   <= sel;
    wb_dat_w <= wdat;
    @(posedge pclk);  // Request accepted here
    cycles = 0;
    @(negedge pclk);
    // Setup cycle, chip select low with the request on the pins
    push_check("mem_cs_n", mem_cs_n, 0);
    push_check("mem_addr", mem_addr, adr);
    push_check("mem_be_n", mem_be_n, smc_pkg::sel_t'(~sel));
    if (we)
    begin
      push_check("mem_dout", mem_dout, wdat);
    end
    while (!wb_ack && cycles < ACK_TIMEOUT)
    begin
      @(negedge pclk);
      cycles++;
    end
    if (!wb_ack)
    begin
      stop_on_timeout("no wb_ack from the controller");
    end
    else
    begin
      rdat = wb_dat_r;
      lat  = cycles;
    end
  endtask

  task automatic wb_write(input smc_pkg::addr_t a, input smc_pkg::sel_t s,
                          input smc_pkg::data_t d);
    smc_pkg::data_t rd;
    int             lat;
    wb_cycle(1'b1, a, s, d, rd, lat);
    shadow[a] = merge_bytes(known_word(a), d, s);
    push_check("write ack latency", lat, ack_latency(1'b1));
  endtask

  task automatic wb_read(input smc_pkg::addr_t a);
    smc_pkg::data_t rd;
    int             lat;
    wb_cycle(1'b0, a, 4'hf, '0, rd, lat);
    push_check("wb_dat_r", rd, known_word(a));
    push_check("read ack latency", lat, ack_latency(1'b0));
  endtask

  task automatic bus_idle();
    @(posedge pclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial
  begin
    smc_pkg::data_t d;
    smc_pkg::addr_t a;
    smc_pkg::addr_t base;
    smc_pkg::addr_t addrs[8];
    int             fails;
    void'($urandom(32'h64568cfe));
    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    repeat (8) @(posedge pclk);
    reset <= 1'b0;
    cur_rd   = 2;  // Reset timing
    cur_wr   = 2;
    cur_hold = 1;

    start_test();
    apb_read(smc_pkg::CFG_ADDR, d);
    push_check("prdata", d, pack_cfg(2, 2, 1));
    @(negedge pclk);
    push_check("mem_cs_n", mem_cs_n, 1);
    push_check("mem_oe_n", mem_oe_n, 1);
    push_check("mem_we_n", mem_we_n, 1);
    push_check("mem_be_n", mem_be_n, 4'hf);
    push_check("mem_doe", mem_doe, 0);
    push_check("wb_ack", wb_ack, 0);
    end_test("reset state");

    start_test();
    apb_write(smc_pkg::CFG_ADDR, 32'hffff_f5a7);
    apb_read(smc_pkg::CFG_ADDR, d);
    push_check("prdata", d, 32'hffff_f5a7 & 32'h0000_03ff);  // Fields only
    apb_write(5'h04, 32'h0000_0333);
    apb_read(smc_pkg::CFG_ADDR, d);
    push_check("prdata", d, 32'hffff_f5a7 & 32'h0000_03ff);
    apb_read(5'h04, d);
    push_check("prdata", d, '0);
    end_test("apb register");
    set_config(1, 3, 1);

    start_test();
    for (int i = 0; i < 8; i++)
    begin
      addrs[i] = smc_pkg::addr_t'($urandom);
      wb_write(addrs[i], 4'hf, $urandom);
    end
    for (int i = 0; i < 8; i++) wb_read(addrs[i]);
    bus_idle();
    end_test("full word write and read");

    start_test();
    a = smc_pkg::addr_t'($urandom);
    wb_write(a, 4'hf, $urandom);
    for (int i = 0; i < 8; i++)
    begin
      wb_write(a, smc_pkg::sel_t'($urandom), $urandom);  // Random lane mix
      wb_read(a);
    end
    bus_idle();
    end_test("byte lane write");

    start_test();
    for (int i = 0; i < 6; i++)
    begin
      // Every other setting skips the hold phase
      set_config($urandom_range(0, 15), $urandom_range(0, 15),
                 (i % 2 == 0) ? 0 : $urandom_range(1, 3));
      a = smc_pkg::addr_t'($urandom);
      wb_write(a, 4'hf, $urandom);
      wb_read(a);
      bus_idle();
    end
    end_test("wait states and hold");

    start_test();
    set_config(0, 1, 0);
    base = smc_pkg::addr_t'($urandom);
    for (int i = 0; i < 40; i++)
    begin
      a = {base[smc_pkg::ADDR_W-1:4], 4'($urandom_range(0, 15))};  // Small pool for hits
      if ($urandom_range(0, 1) == 1) wb_write(a, smc_pkg::sel_t'($urandom), $urandom);
      else wb_read(a);
    end
    bus_idle();
    end_test("random back to back");

    fails = UUT.i_chk.fails;
    $display("%0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, fails);
    if (error_count == 0 && fails == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hw/smc_pkg.sv
hw/smc_apb_if.sv
hw/smc_wait_timer.sv
hw/smc_data_path.sv
hw/smc_state_machine.sv
hw/smc_top.sv
bench/smc_sram_model.sv
bench/smc_chk.sv
bench/smc_tb.sv

//--- hw/smc_apb_if.sv
/*
 * APB slave for the controller configuration
 * Address decode in the access phase, timing register, read mux
 */

`timescale 1ns/1ps
`default_nettype none

module smc_apb_if (
  input  wire                      pclk,
  input  wire                      reset,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire smc_pkg::apb_addr_t  paddr,
  input  wire smc_pkg::data_t      pwdata,
  output smc_pkg::data_t           prdata,
  output smc_pkg::smc_cfg_t        cfg
);

  logic              sel_reg;  // Config register addressed in access phase
  smc_pkg::smc_cfg_t cfg_q;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  always_comb
  begin
    if (psel && penable)
    begin
      sel_reg = (paddr == smc_pkg::CFG_ADDR);
    end
    else
    begin
      sel_reg = 1'b0;  // Setup phase or no select
    end
  end

  // --------------------------------------------------
  // Timing register
  // --------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      cfg_q <= smc_pkg::CFG_RESET;
    end
    else if (sel_reg && pwrite)
    begin
      // Only the low bits hold fields, the rest are dropped
      cfg_q <= smc_pkg::smc_cfg_t'(pwdata[$bits(smc_pkg::smc_cfg_t)-1:0]);
    end
  end

  // Read mux, upper bits zero
  assign prdata = sel_reg ? smc_pkg::data_t'(cfg_q) : '0;
  assign cfg    = cfg_q;  // To the sequencer

endmodule

`default_nettype wire

//--- hw/smc_data_path.sv
/*
 * Memory data path
 * Request latch, registered active-low strobes, byte enables
 * Read data capture towards the host
 */

`timescale 1ns/1ps
`default_nettype none

module smc_data_path (
  input  wire                  pclk,
  input  wire                  reset,
  input  wire                  load_req,
  input  wire                  capture,
  input  wire                  phase_cs,
  input  wire                  phase_oe,
  input  wire                  phase_we,
  input  wire                  wb_we,
  input  wire smc_pkg::addr_t  wb_adr,
  input  wire smc_pkg::sel_t   wb_sel,
  input  wire smc_pkg::data_t  wb_dat_w,
  input  wire smc_pkg::data_t  mem_din,
  output smc_pkg::data_t       wb_dat_r,
  output smc_pkg::addr_t       mem_addr,
  output smc_pkg::data_t       mem_dout,
  output logic                 mem_doe,
  output logic                 mem_cs_n,
  output logic                 mem_oe_n,
  output logic                 mem_we_n,
  output smc_pkg::sel_t        mem_be_n
);

  smc_pkg::smc_req_t req;

  // --------------------------------------------------
  // Request latch
  // --------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (load_req)
    begin
      req.addr  <= wb_adr;
      req.wdata <= wb_dat_w;
      req.sel   <= wb_sel;
      req.we    <= wb_we;
    end
  end

  // Strobes registered so the pins are glitch free
  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      mem_cs_n <= 1'b1;
      mem_oe_n <= 1'b1;
      mem_we_n <= 1'b1;
      mem_doe  <= 1'b0;
    end
    else
    begin
      mem_cs_n <= !phase_cs;
      mem_oe_n <= !phase_oe;
      mem_we_n <= !phase_we;
      mem_doe  <= phase_we;  // Drive the bus only under the write strobe
    end
  end

  // Read data sampled on the last access edge
  always_ff @(posedge pclk)
  begin
    if (capture && !req.we)
    begin
      wb_dat_r <= mem_din;
    end
  end

  assign mem_addr = req.addr;
  assign mem_dout = req.wdata;
  assign mem_be_n = mem_cs_n ? '1 : ~req.sel;  // Lanes idle outside chip select

endmodule

`default_nettype wire

//--- hw/smc_pkg.sv
/*
 * Static memory controller shared definitions
 * Widths and vector types for address, data, byte lanes and timing fields
 * Configuration and latched request structs
 * Sequencer state enum, register address and reset value
 */

`default_nettype none

package smc_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int ADDR_W     = 16;  // Memory word address
  localparam int DATA_W     = 32;
  localparam int WAIT_W     = 4;   // Wait state field
  localparam int HOLD_W     = 2;   // Hold field
  localparam int SEL_W      = DATA_W / 8;
  localparam int APB_ADDR_W = 5;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [SEL_W-1:0]      sel_t;      // One enable per byte lane
  typedef logic [WAIT_W-1:0]     wait_t;
  typedef logic [HOLD_W-1:0]     hold_t;
  typedef logic [APB_ADDR_W-1:0] apb_addr_t; // Byte address

  // --------------------------------------------------
  // Structs
  // --------------------------------------------------
  // Field order gives the prdata layout, hold 9:8, wr_wait 7:4, rd_wait 3:0
  typedef struct packed {
    hold_t hold;     // Cycles of chip select after the strobe
    wait_t wr_wait;  // Extra write strobe cycles
    wait_t rd_wait;  // Extra read strobe cycles
  } smc_cfg_t;

  // Host request as held for the whole memory cycle
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    sel_t  sel;
    logic  we;
  } smc_req_t;

  // Memory cycle phases
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_HOLD,
    ST_ACK
  } smc_state_t;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam apb_addr_t CFG_ADDR  = 5'h00;
  localparam smc_cfg_t  CFG_RESET = '{hold: 2'd1, wr_wait: 4'd2, rd_wait: 4'd2};

endpackage

`default_nettype wire

//--- hw/smc_state_machine.sv
/*
 * Memory cycle sequencer
 * Idle, setup, access, hold and ack phases
 * Timer control, strobe phase outputs and Wishbone acknowledge
 */

`timescale 1ns/1ps
`default_nettype none

module smc_state_machine (
  input  wire                      pclk,
  input  wire                      reset,
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire smc_pkg::smc_cfg_t   cfg,
  input  wire                      timer_done,
  output logic                     wb_ack,
  output logic                     load_req,
  output logic                     capture,
  output logic                     phase_cs,
  output logic                     phase_oe,
  output logic                     phase_we,
  output logic                     timer_load,
  output smc_pkg::wait_t           timer_value
);

  smc_pkg::smc_state_t state;
  smc_pkg::smc_state_t state_nxt;
  smc_pkg::smc_cfg_t   cfg_q;     // Timing frozen for the current cycle
  logic                we_q;      // Direction of the current cycle
  logic                start;     // Request accepted this edge
  logic                has_hold;

  assign start    = (state == smc_pkg::ST_IDLE) && wb_cyc && wb_stb;
  assign has_hold = (cfg_q.hold != '0);

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      smc_pkg::ST_IDLE:   if (start) state_nxt = smc_pkg::ST_SETUP;
      smc_pkg::ST_SETUP:  state_nxt = smc_pkg::ST_ACCESS;  // Always one cycle
      smc_pkg::ST_ACCESS:
        if (timer_done)
        begin
          state_nxt = has_hold ? smc_pkg::ST_HOLD : smc_pkg::ST_ACK;
        end
      smc_pkg::ST_HOLD:   if (timer_done) state_nxt = smc_pkg::ST_ACK;
      smc_pkg::ST_ACK:    state_nxt = smc_pkg::ST_IDLE;    // At least one idle cycle
      default:            state_nxt = smc_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      state <= smc_pkg::ST_IDLE;
      cfg_q <= smc_pkg::CFG_RESET;
      we_q  <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (start)
      begin
        cfg_q <= cfg;    // Later APB writes wait for the next cycle
        we_q  <= wb_we;
      end
    end
  end

  // Phase outputs follow the next state so the registered pins track state
  assign phase_cs = (state_nxt == smc_pkg::ST_SETUP) ||
                    (state_nxt == smc_pkg::ST_ACCESS) ||
                    (state_nxt == smc_pkg::ST_HOLD);
  assign phase_oe = (state_nxt == smc_pkg::ST_ACCESS) && !we_q;
  assign phase_we = (state_nxt == smc_pkg::ST_ACCESS) && we_q;

  // Timer loaded on entry to access and to hold
  assign timer_load = (state == smc_pkg::ST_SETUP) ||
                      ((state == smc_pkg::ST_ACCESS) && timer_done && has_hold);
  // Hold count less one, since the entry edge already starts the phase
  assign timer_value = (state == smc_pkg::ST_SETUP)
                       ? (we_q ? cfg_q.wr_wait : cfg_q.rd_wait)
                       : smc_pkg::wait_t'(cfg_q.hold) - smc_pkg::wait_t'(1);

  assign load_req = start;
  assign capture  = (state == smc_pkg::ST_ACCESS) && timer_done && !we_q;  // Last read edge
  assign wb_ack   = (state == smc_pkg::ST_ACK);

endmodule

`default_nettype wire

//--- hw/smc_top.sv
/*
 * Static memory controller top level
 * APB configuration port, Wishbone host port, SRAM pins
 */

`timescale 1ns/1ps
`default_nettype none

module smc_top (
  input  wire                      pclk,
  input  wire                      reset,
  // APB configuration
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire smc_pkg::apb_addr_t  paddr,
  input  wire smc_pkg::data_t      pwdata,
  output smc_pkg::data_t           prdata,
  // Wishbone host
  input  wire                      wb_cyc,
  input  wire                      wb_stb,
  input  wire                      wb_we,
  input  wire smc_pkg::addr_t      wb_adr,
  input  wire smc_pkg::sel_t       wb_sel,
  input  wire smc_pkg::data_t      wb_dat_w,
  output smc_pkg::data_t           wb_dat_r,
  output logic                     wb_ack,
  // SRAM pins
  output smc_pkg::addr_t           mem_addr,
  output smc_pkg::data_t           mem_dout,
  output logic                     mem_doe,
  output logic                     mem_cs_n,
  output logic                     mem_oe_n,
  output logic                     mem_we_n,
  output smc_pkg::sel_t            mem_be_n,
  input  wire smc_pkg::data_t      mem_din
);

  smc_pkg::smc_cfg_t cfg;
  smc_pkg::wait_t    timer_value;
  logic              timer_load;
  logic              timer_done;
  logic              load_req;
  logic              capture;
  logic              phase_cs;
  logic              phase_oe;
  logic              phase_we;

  smc_apb_if i_apb_if (
    .pclk    (pclk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .cfg     (cfg)
  );

  smc_state_machine i_state_machine (
    .pclk        (pclk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .cfg         (cfg),
    .timer_done  (timer_done),
    .wb_ack      (wb_ack),
    .load_req    (load_req),
    .capture     (capture),
    .phase_cs    (phase_cs),
    .phase_oe    (phase_oe),
    .phase_we    (phase_we),
    .timer_load  (timer_load),
    .timer_value (timer_value)
  );

  smc_wait_timer i_wait_timer (
    .pclk  (pclk),
    .reset (reset),
    .load  (timer_load),
    .value (timer_value),
    .done  (timer_done)
  );

  smc_data_path i_data_path (
    .pclk     (pclk),
    .reset    (reset),
    .load_req (load_req),
    .capture  (capture),
    .phase_cs (phase_cs),
    .phase_oe (phase_oe),
    .phase_we (phase_we),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_w (wb_dat_w),
    .mem_din  (mem_din),
    .wb_dat_r (wb_dat_r),
    .mem_addr (mem_addr),
    .mem_dout (mem_dout),
    .mem_doe  (mem_doe),
    .mem_cs_n (mem_cs_n),
    .mem_oe_n (mem_oe_n),
    .mem_we_n (mem_we_n),
    .mem_be_n (mem_be_n)
  );

endmodule

`default_nettype wire

//--- hw/smc_wait_timer.sv
/*
 * Wait state timer
 * Loadable down-counter, done while the count is zero
 */

`timescale 1ns/1ps
`default_nettype none

module smc_wait_timer (
  input  wire                  pclk,
  input  wire                  reset,
  input  wire                  load,
  input  wire smc_pkg::wait_t  value,
  output logic                 done
);

  smc_pkg::wait_t count;

  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else if (load)
    begin
      count <= value;  // Done follows value cycles later
    end
    else if (count != '0)
    begin
      count <= count - smc_pkg::wait_t'(1);
    end
    // Zero is sticky until the next load
  end

  assign done = (count == '0);

endmodule

`default_nettype wire
